// ==== verilog/dcd_cfg.svh ====
// DCD calibration configuration
`ifndef DCD_CFG_SVH
`define DCD_CFG_SVH

// Channel pass
`define DCD_NUM_CHANNELS  4
`define DCD_CHAN_W        10

// Comparator settle wait in clock cycles
`define DCD_SETTLE_CYCLES 16

// Register addresses on the basic-block port
`define DCD_ADDR_REQUEST  12'h010
`define DCD_ADDR_ID       12'h011
`define DCD_ADDR_CLKMON   12'h020
`define DCD_ADDR_LST      12'h021
`define DCD_ADDR_DCTUNE   12'h022

// Field values
`define DCD_TUNE_DEFAULT  3'd3
`define DCD_LST_ON        4'b1100

// Bit offsets inside the 16-bit register word
`define DCD_REQ_OFST      2
`define DCD_TXID_OFST     5
`define DCD_CLKMON_OFST   13
`define DCD_LST_OFST      8
`define DCD_TUNE_OFST     4

`endif

// ==== verilog/dcd_pkg.sv ====
// DCD calibration types
`default_nettype none
`include "dcd_cfg.svh"

package dcd_pkg;

  typedef logic [2:0] dcd_tune_t;
  typedef logic [`DCD_CHAN_W-1:0] dcd_chan_t;

  // Request and ID registers
  typedef struct packed {
    logic [14-`DCD_TXID_OFST:0]              pad_hi;
    logic                                    tx_present;
    logic [`DCD_TXID_OFST-`DCD_REQ_OFST-2:0] pad_mid;
    logic                                    request;
    logic [`DCD_REQ_OFST-1:0]                pad_lo;
  } dcd_status_s;

  // PMA control registers, LST field is 4 bits and tune is 3 bits
  typedef struct packed {
    logic [14-`DCD_CLKMON_OFST:0]               pad_hi;
    logic                                       clkmon;
    logic [`DCD_CLKMON_OFST-`DCD_LST_OFST-5:0]  pad_lst;
    logic [3:0]                                 lst;
    logic [`DCD_LST_OFST-`DCD_TUNE_OFST-4:0]    pad_tune;
    dcd_tune_t                                  tune;
    logic [`DCD_TUNE_OFST-1:0]                  pad_lo;
  } dcd_pma_s;

  typedef union packed {
    dcd_status_s status;
    dcd_pma_s    pma;
  } dcd_word_u;

  typedef enum logic [3:0] {
    step_read_request,
    step_read_id,
    step_read_clkmon,
    step_write_clkmon_on,
    step_write_clkmon_off,
    step_read_lst,
    step_write_lst_on,
    step_write_lst_off,
    step_read_dctune,
    step_write_dctune
  } dcd_step_e;

endpackage

`default_nettype wire

// ==== verilog/dcd_comparator_monitor.sv ====
// Comparator sampling and settle timer
`timescale 1ns/1ps
`default_nettype none
`include "dcd_cfg.svh"

module dcd_comparator_monitor (
  input  logic clk,
  input  logic reset,
  input  logic lch_atbout,
  input  logic settle_start,
  input  logic capture_ref,
  output logic settle_done,
  output logic level,
  output logic toggled
);

  localparam int cnt_w = $clog2(`DCD_SETTLE_CYCLES);

  logic [1:0]       sync_ff;
  logic [cnt_w-1:0] count;
  logic             ref_level;

  // Change against the level seen after the default tune
  assign toggled = (level != ref_level);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync_ff     <= 2'b00;
      count       <= '0;
      settle_done <= 1'b0;
      level       <= 1'b0;
      ref_level   <= 1'b0;
    end else begin
      sync_ff     <= {sync_ff[0], lch_atbout};
      settle_done <= 1'b0;
      if (settle_start) begin
        count <= cnt_w'(`DCD_SETTLE_CYCLES - 1);
      end else if (count != '0) begin
        count <= count - 1'b1;
        // Last cycle of the wait
        if (count == cnt_w'(1)) begin
          settle_done <= 1'b1;
          level       <= sync_ff[1];
        end
      end
      if (capture_ref) begin
        ref_level <= level;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcd_tune_search.sv ====
// dc_tune sweep register
`timescale 1ns/1ps
`default_nettype none
`include "dcd_cfg.svh"

module dcd_tune_search (
  input  logic               clk,
  input  logic               reset,
  input  logic               load_default,
  input  logic               capture,
  input  logic               advance,
  input  logic               level,
  input  logic               toggled,
  output dcd_pkg::dcd_tune_t value,
  output dcd_pkg::dcd_tune_t final_value,
  output logic               search_over
);

  dcd_pkg::dcd_tune_t prev_value;
  logic               dir_down;
  logic               at_limit;

  // Sweep stops at 0 going down or at 7 going up
  assign at_limit    = dir_down ? (value == '0) : (value == '1);
  assign search_over = toggled || at_limit;

  // Keep the setting before the comparator flipped
  assign final_value = toggled ? prev_value : value;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      value      <= `DCD_TUNE_DEFAULT;
      prev_value <= `DCD_TUNE_DEFAULT;
      dir_down   <= 1'b0;
    end else begin
      if (load_default) begin
        value      <= `DCD_TUNE_DEFAULT;
        prev_value <= `DCD_TUNE_DEFAULT;
      end else if (advance) begin
        prev_value <= value;
        value      <= dir_down ? value - 1'b1 : value + 1'b1;
      end
      // Comparator high means duty cycle too long, step down
      if (capture) begin
        dir_down <= level;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcd_access_port.sv ====
// Basic-block register access port
`timescale 1ns/1ps
`default_nettype none
`include "dcd_cfg.svh"

module dcd_access_port (
  input  logic               clk,
  input  logic               reset,
  input  logic               step_req,
  input  dcd_pkg::dcd_step_e step_kind,
  input  dcd_pkg::dcd_tune_t step_tune,
  input  logic               ctrl_done,
  input  dcd_pkg::dcd_word_u ctrl_rdata,
  output logic               ctrl_go,
  output logic [11:0]        ctrl_addr,
  output logic [2:0]         ctrl_opcode,
  output dcd_pkg::dcd_word_u ctrl_wdata
);

  localparam logic [2:0] opc_read  = 3'h0;
  localparam logic [2:0] opc_write = 3'h1;

  dcd_pkg::dcd_word_u rd_word;
  dcd_pkg::dcd_word_u wr_word;
  logic [11:0]        addr_next;
  logic [2:0]         opcode_next;

  // Address and opcode per step
  always_comb begin
    addr_next   = `DCD_ADDR_REQUEST;
    opcode_next = opc_write;
    case (step_kind)
      dcd_pkg::step_read_request: begin
        addr_next   = `DCD_ADDR_REQUEST;
        opcode_next = opc_read;
      end
      dcd_pkg::step_read_id: begin
        addr_next   = `DCD_ADDR_ID;
        opcode_next = opc_read;
      end
      dcd_pkg::step_read_clkmon: begin
        addr_next   = `DCD_ADDR_CLKMON;
        opcode_next = opc_read;
      end
      dcd_pkg::step_write_clkmon_on,
      dcd_pkg::step_write_clkmon_off: addr_next = `DCD_ADDR_CLKMON;
      dcd_pkg::step_read_lst: begin
        addr_next   = `DCD_ADDR_LST;
        opcode_next = opc_read;
      end
      dcd_pkg::step_write_lst_on,
      dcd_pkg::step_write_lst_off: addr_next = `DCD_ADDR_LST;
      dcd_pkg::step_read_dctune: begin
        addr_next   = `DCD_ADDR_DCTUNE;
        opcode_next = opc_read;
      end
      default: addr_next = `DCD_ADDR_DCTUNE;
    endcase
  end

  // Read-modify-write: one field replaced in the last read word
  always_comb begin
    wr_word = rd_word;
    case (step_kind)
      dcd_pkg::step_write_clkmon_on:  wr_word.pma.clkmon = 1'b1;
      dcd_pkg::step_write_clkmon_off: wr_word.pma.clkmon = 1'b0;
      dcd_pkg::step_write_lst_on:     wr_word.pma.lst = `DCD_LST_ON;
      dcd_pkg::step_write_lst_off:    wr_word.pma.lst = 4'b0000;
      dcd_pkg::step_write_dctune:     wr_word.pma.tune = step_tune;
      default:                        wr_word = '0;
    endcase
  end

  // Go trails the request so address and data are already settled
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_go     <= 1'b0;
      ctrl_addr   <= '0;
      ctrl_opcode <= opc_read;
    end else begin
      ctrl_go <= step_req;
      if (step_req) begin
        ctrl_addr   <= addr_next;
        ctrl_opcode <= opcode_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step_req) begin
      ctrl_wdata <= wr_word;
    end
    // Keep the word of the last completed read
    if (ctrl_done && (ctrl_opcode == opc_read)) begin
      rd_word <= ctrl_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcd_sequencer.sv ====
// DCD channel loop and calibration FSM
`timescale 1ns/1ps
`default_nettype none
`include "dcd_cfg.svh"

module dcd_sequencer (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               ctrl_done,
  input  logic               ctrl_chan_err,
  input  dcd_pkg::dcd_word_u ctrl_rdata,
  input  logic               settle_done,
  input  logic               search_over,
  input  dcd_pkg::dcd_tune_t value,
  input  dcd_pkg::dcd_tune_t final_value,
  output dcd_pkg::dcd_chan_t ctrl_chan,
  output logic               ctrl_lock,
  output logic               done,
  output logic               busy,
  output logic               step_req,
  output dcd_pkg::dcd_step_e step_kind,
  output dcd_pkg::dcd_tune_t step_tune,
  output logic               settle_start,
  output logic               capture_ref,
  output logic               capture,
  output logic               advance,
  output logic               load_default
);

  localparam logic [4:0] st_idle           = 5'd0;
  localparam logic [4:0] st_req            = 5'd1;
  localparam logic [4:0] st_id             = 5'd2;
  localparam logic [4:0] st_rd_clkmon_on   = 5'd3;
  localparam logic [4:0] st_wr_clkmon_on   = 5'd4;
  localparam logic [4:0] st_rd_lst_on      = 5'd5;
  localparam logic [4:0] st_wr_lst_on      = 5'd6;
  localparam logic [4:0] st_rd_tune        = 5'd7;
  localparam logic [4:0] st_wr_default     = 5'd8;
  localparam logic [4:0] st_settle_default = 5'd9;
  localparam logic [4:0] st_decide         = 5'd10;
  localparam logic [4:0] st_step           = 5'd11;
  localparam logic [4:0] st_wr_step        = 5'd12;
  localparam logic [4:0] st_settle_step    = 5'd13;
  localparam logic [4:0] st_wr_final       = 5'd14;
  localparam logic [4:0] st_rd_clkmon_off  = 5'd15;
  localparam logic [4:0] st_wr_clkmon_off  = 5'd16;
  localparam logic [4:0] st_rd_lst_off     = 5'd17;
  localparam logic [4:0] st_wr_lst_off     = 5'd18;

  logic [4:0]         state;
  logic [4:0]         state_next;
  logic               issue;
  dcd_pkg::dcd_step_e kind_next;
  dcd_pkg::dcd_tune_t tune_next;
  logic               chan_end;
  logic               chan_last;

  assign chan_last = (ctrl_chan == dcd_pkg::dcd_chan_t'(`DCD_NUM_CHANNELS - 1));

  // Strobes to the comparator monitor and tune search
  assign load_default = (state == st_rd_tune) && ctrl_done;
  assign settle_start = ctrl_done && ((state == st_wr_default) || (state == st_wr_step));
  assign capture_ref  = (state == st_settle_default) && settle_done;
  assign capture      = capture_ref;
  assign advance      = (state == st_decide) && !search_over;

  always_comb begin
    state_next = state;
    issue      = 1'b0;
    kind_next  = dcd_pkg::step_read_request;
    tune_next  = step_tune;
    chan_end   = 1'b0;
    case (state)
      st_idle: if (start) begin
        state_next = st_req;
        issue      = 1'b1;
      end
      st_req: if (ctrl_done) begin
        if (ctrl_chan_err || !ctrl_rdata.status.request) begin
          chan_end = 1'b1;
        end else begin
          state_next = st_id;
          issue      = 1'b1;
          kind_next  = dcd_pkg::step_read_id;
        end
      end
      st_id: if (ctrl_done) begin
        if (!ctrl_rdata.status.tx_present) begin
          chan_end = 1'b1;
        end else begin
          state_next = st_rd_clkmon_on;
          issue      = 1'b1;
          kind_next  = dcd_pkg::step_read_clkmon;
        end
      end
      st_rd_clkmon_on: if (ctrl_done) begin
        state_next = st_wr_clkmon_on;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_write_clkmon_on;
      end
      st_wr_clkmon_on: if (ctrl_done) begin
        state_next = st_rd_lst_on;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_read_lst;
      end
      st_rd_lst_on: if (ctrl_done) begin
        state_next = st_wr_lst_on;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_write_lst_on;
      end
      st_wr_lst_on: if (ctrl_done) begin
        state_next = st_rd_tune;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_read_dctune;
      end
      st_rd_tune: if (ctrl_done) begin
        state_next = st_wr_default;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_write_dctune;
        tune_next  = `DCD_TUNE_DEFAULT;
      end
      st_wr_default: if (ctrl_done) begin
        state_next = st_settle_default;
      end
      st_settle_default: if (settle_done) begin
        state_next = st_decide;
      end
      // Search result is valid one cycle after capture or a settled step
      st_decide: begin
        if (search_over) begin
          state_next = st_wr_final;
          issue      = 1'b1;
          kind_next  = dcd_pkg::step_write_dctune;
          tune_next  = final_value;
        end else begin
          state_next = st_step;
        end
      end
      // Value has moved one step by now
      st_step: begin
        state_next = st_wr_step;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_write_dctune;
        tune_next  = value;
      end
      st_wr_step: if (ctrl_done) begin
        state_next = st_settle_step;
      end
      st_settle_step: if (settle_done) begin
        state_next = st_decide;
      end
      st_wr_final: if (ctrl_done) begin
        state_next = st_rd_clkmon_off;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_read_clkmon;
      end
      st_rd_clkmon_off: if (ctrl_done) begin
        state_next = st_wr_clkmon_off;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_write_clkmon_off;
      end
      st_wr_clkmon_off: if (ctrl_done) begin
        state_next = st_rd_lst_off;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_read_lst;
      end
      st_rd_lst_off: if (ctrl_done) begin
        state_next = st_wr_lst_off;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_write_lst_off;
      end
      st_wr_lst_off: if (ctrl_done) begin
        chan_end = 1'b1;
      end
      default: state_next = st_idle;
    endcase

    // Next channel or end of pass
    if (chan_end) begin
      if (chan_last) begin
        state_next = st_idle;
      end else begin
        state_next = st_req;
        issue      = 1'b1;
        kind_next  = dcd_pkg::step_read_request;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= st_idle;
      step_req  <= 1'b0;
      ctrl_chan <= '0;
      ctrl_lock <= 1'b0;
      done      <= 1'b0;
      busy      <= 1'b0;
    end else begin
      state    <= state_next;
      step_req <= issue;
      if ((state == st_idle) && start) begin
        busy      <= 1'b1;
        done      <= 1'b0;
        ctrl_chan <= '0;
      end
      if (issue && (kind_next == dcd_pkg::step_read_id)) begin
        ctrl_lock <= 1'b1;
      end
      if (chan_end) begin
        ctrl_lock <= 1'b0;
        if (chan_last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          ctrl_chan <= ctrl_chan + dcd_pkg::dcd_chan_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      step_kind <= kind_next;
      step_tune <= tune_next;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcd_calibration_top.sv ====
// DCD calibration controller
`timescale 1ns/1ps
`default_nettype none

module dcd_calibration_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               lch_atbout,
  output logic               done,
  output logic               busy,
  // Basic-block register port
  output logic               ctrl_go,
  output logic               ctrl_lock,
  input  logic               ctrl_done,
  output dcd_pkg::dcd_chan_t ctrl_chan,
  input  logic               ctrl_chan_err,
  output logic [11:0]        ctrl_addr,
  output logic [2:0]         ctrl_opcode,
  output dcd_pkg::dcd_word_u ctrl_wdata,
  input  dcd_pkg::dcd_word_u ctrl_rdata
);

  logic               step_req;
  dcd_pkg::dcd_step_e step_kind;
  dcd_pkg::dcd_tune_t step_tune;
  logic               settle_start;
  logic               settle_done;
  logic               capture_ref;
  logic               level;
  logic               toggled;
  logic               load_default;
  logic               capture;
  logic               advance;
  logic               search_over;
  dcd_pkg::dcd_tune_t value;
  dcd_pkg::dcd_tune_t final_value;

  dcd_sequencer u_sequencer (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .ctrl_done     (ctrl_done),
    .ctrl_chan_err (ctrl_chan_err),
    .ctrl_rdata    (ctrl_rdata),
    .settle_done   (settle_done),
    .search_over   (search_over),
    .value         (value),
    .final_value   (final_value),
    .ctrl_chan     (ctrl_chan),
    .ctrl_lock     (ctrl_lock),
    .done          (done),
    .busy          (busy),
    .step_req      (step_req),
    .step_kind     (step_kind),
    .step_tune     (step_tune),
    .settle_start  (settle_start),
    .capture_ref   (capture_ref),
    .capture       (capture),
    .advance       (advance),
    .load_default  (load_default)
  );

  dcd_access_port u_access_port (
    .clk         (clk),
    .reset       (reset),
    .step_req    (step_req),
    .step_kind   (step_kind),
    .step_tune   (step_tune),
    .ctrl_done   (ctrl_done),
    .ctrl_rdata  (ctrl_rdata),
    .ctrl_go     (ctrl_go),
    .ctrl_addr   (ctrl_addr),
    .ctrl_opcode (ctrl_opcode),
    .ctrl_wdata  (ctrl_wdata)
  );

  dcd_comparator_monitor u_comparator_monitor (
    .clk          (clk),
    .reset        (reset),
    .lch_atbout   (lch_atbout),
    .settle_start (settle_start),
    .capture_ref  (capture_ref),
    .settle_done  (settle_done),
    .level        (level),
    .toggled      (toggled)
  );

  dcd_tune_search u_tune_search (
    .clk          (clk),
    .reset        (reset),
    .load_default (load_default),
    .capture      (capture),
    .advance      (advance),
    .level        (level),
    .toggled      (toggled),
    .value        (value),
    .final_value  (final_value),
    .search_over  (search_over)
  );

endmodule

`default_nettype wire

// ==== sim/dcd_xcvr_model.sv ====
// Transceiver register file model
`timescale 1ns/1ps
`default_nettype none
`include "dcd_cfg.svh"

module dcd_xcvr_model (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ctrl_go,
  input  logic [`DCD_CHAN_W-1:0] ctrl_chan,
  input  logic [11:0]            ctrl_addr,
  input  logic [2:0]             ctrl_opcode,
  input  logic [15:0]            ctrl_wdata,
  output logic                   ctrl_done,
  output logic [15:0]            ctrl_rdata,
  output logic                   ctrl_chan_err,
  output logic                   lch_atbout
);

  localparam int nch = `DCD_NUM_CHANNELS;

  int          seed = 46536;
  logic [15:0] regs [nch][5];
  logic [2:0]  threshold [nch];
  bit          err_flag [nch];
  int          wait_cycles;
  int          acc_chan;
  int          acc_reg;
  bit          acc_write;
  logic [15:0] acc_data;

  // Register slot per address, -1 when unmapped
  function automatic int reg_index(input logic [11:0] addr);
    case (addr)
      `DCD_ADDR_REQUEST: return 0;
      `DCD_ADDR_ID:      return 1;
      `DCD_ADDR_CLKMON:  return 2;
      `DCD_ADDR_LST:     return 3;
      `DCD_ADDR_DCTUNE:  return 4;
      default:           return -1;
    endcase
  endfunction

  // Random padding, chosen status bits and threshold for one channel
  task automatic configure(input int ch, input int th_in, input bit req, input bit txp,
                           input bit err, output logic [2:0] th);
    int k;
    for (k = 0; k < 5; k++) begin
      regs[ch][k] = 16'($random(seed));
    end
    regs[ch][0][`DCD_REQ_OFST]  = req;
    regs[ch][1][`DCD_TXID_OFST] = txp;
    if (th_in < 0) begin
      th = 3'($random(seed));
    end else begin
      th = 3'(th_in);
    end
    threshold[ch] = th;
    err_flag[ch]  = err;
  endtask

  initial begin
    ctrl_done     = 1'b0;
    ctrl_rdata    = '0;
    ctrl_chan_err = 1'b0;
    lch_atbout    = 1'b0;
    wait_cycles   = 0;
    for (int c = 0; c < nch; c++) begin
      threshold[c] = 3'd0;
      err_flag[c]  = 1'b0;
      for (int k = 0; k < 5; k++) begin
        regs[c][k] = 16'((c << 4) | k);
      end
    end
    forever begin
      @(posedge clk);
      #1;
      ctrl_done     = 1'b0;
      ctrl_chan_err = 1'b0;
      if (reset) begin
        wait_cycles = 0;
      end else if (wait_cycles > 0) begin
        wait_cycles = wait_cycles - 1;
        if (wait_cycles == 0) begin
          ctrl_done     = 1'b1;
          ctrl_chan_err = err_flag[acc_chan];
          ctrl_rdata    = '0;
          if (acc_reg >= 0 && acc_write) begin
            regs[acc_chan][acc_reg] = acc_data;
          end else if (acc_reg >= 0) begin
            ctrl_rdata = regs[acc_chan][acc_reg];
          end
        end
      end else if (ctrl_go && ctrl_chan < nch) begin
        acc_chan    = int'(ctrl_chan);
        acc_reg     = reg_index(ctrl_addr);
        acc_write   = (ctrl_opcode == 3'd1);
        acc_data    = ctrl_wdata;
        wait_cycles = 1 + ({$random(seed)} % 4);
      end
      // Comparator trips once dc_tune reaches the channel threshold
      if (ctrl_chan < nch) begin
        lch_atbout = (regs[ctrl_chan][4][`DCD_TUNE_OFST +: 3] >= threshold[ctrl_chan]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/dcd_scoreboard.sv ====
// DCD calibration scoreboard
`timescale 1ns/1ps
`default_nettype none
`include "dcd_cfg.svh"

module dcd_scoreboard (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic                   done,
  input  logic                   busy,
  input  logic                   ctrl_go,
  input  logic                   ctrl_lock,
  input  logic [`DCD_CHAN_W-1:0] ctrl_chan,
  input  logic [11:0]            ctrl_addr,
  input  logic [2:0]             ctrl_opcode,
  output int                     tests_passed,
  output int                     tests_failed
);

  localparam int nch = `DCD_NUM_CHANNELS;

  logic [15:0] init_regs [nch][5];
  bit          calibrate [nch];
  logic [2:0]  exp_tune [nch];
  int          writes [nch];
  int          write_base [nch];
  bit          started = 1'b0;
  bit          pass_open = 1'b0;
  bit          done_hold = 1'b0;
  int          idle_events = 0;
  int          hs_errors = 0;
  int          hs_base = 0;
  int          lock_errors = 0;
  int          lock_base = 0;

  initial begin
    tests_passed = 0;
    tests_failed = 0;
    for (int c = 0; c < nch; c++) begin
      writes[c] = 0;
    end
  end

  always @(posedge clk) begin
    if (!started && (ctrl_go || ctrl_lock || done || busy)) begin
      idle_events++;
    end
    if (!reset) begin
      if (ctrl_go && ctrl_opcode == 3'd1 && ctrl_chan < nch) begin
        writes[ctrl_chan]++;
      end
      // Lock held from the ID read through the LST-off write
      if (ctrl_go && (ctrl_lock != (ctrl_addr != `DCD_ADDR_REQUEST))) begin
        lock_errors++;
      end
      if (done && ctrl_lock) begin
        lock_errors++;
      end
      // busy from the cycle after start until done, done held until the next start
      if ((busy && done) || (pass_open && !busy && !done) || (done_hold && !done)) begin
        hs_errors++;
      end
      if (start) begin
        started   = 1'b1;
        pass_open = 1'b1;
        done_hold = 1'b0;
      end else if (done) begin
        pass_open = 1'b0;
        done_hold = 1'b1;
      end
    end
  end

  task automatic record_result(input string name, input int bad);
    if (bad == 0) begin
      tests_passed++;
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
    end
  endtask

  task automatic expect_channel(input int ch, input bit cal, input logic [2:0] tune);
    for (int k = 0; k < 5; k++) begin
      init_regs[ch][k] = tb_dcd_calibration.xcvr.regs[ch][k];
    end
    calibrate[ch]  = cal;
    exp_tune[ch]   = tune;
    write_base[ch] = writes[ch];
  endtask

  // Calibrated channels end with clkmon off, LST off and the swept tune
  function automatic logic [15:0] expected_word(input int ch, input int k);
    logic [15:0] w;
    w = init_regs[ch][k];
    if (calibrate[ch]) begin
      case (k)
        2:       w[`DCD_CLKMON_OFST] = 1'b0;
        3:       w[`DCD_LST_OFST +: 4] = 4'b0000;
        4:       w[`DCD_TUNE_OFST +: 3] = exp_tune[ch];
        default: w = init_regs[ch][k];
      endcase
    end
    return w;
  endfunction

  task automatic check_idle();
    if (idle_events != 0) begin
      $display("[FAIL] reset_idle: port active in %0d cycles before start", idle_events);
    end
    record_result("reset_idle", idle_events);
  endtask

  task automatic check_pass(input int pass_no);
    string       name;
    logic [15:0] want;
    logic [15:0] got;
    int          bad;
    int          n_writes;
    for (int ch = 0; ch < nch; ch++) begin
      name     = $sformatf("pass%0d_ch%0d", pass_no, ch);
      bad      = 0;
      n_writes = writes[ch] - write_base[ch];
      for (int k = 0; k < 5; k++) begin
        want = expected_word(ch, k);
        got  = tb_dcd_calibration.xcvr.regs[ch][k];
        if (got !== want) begin
          $display("[FAIL] %s reg%0d expected %h actual %h", name, k, want, got);
          bad++;
        end
      end
      if (!calibrate[ch] && n_writes != 0) begin
        $display("[FAIL] %s: skipped channel received %0d writes", name, n_writes);
        bad++;
      end
      record_result(name, bad);
    end
    name = $sformatf("pass%0d_busy_done", pass_no);
    bad  = hs_errors - hs_base;
    hs_base = hs_errors;
    if (bad != 0) begin
      $display("[FAIL] %s: busy or done wrong in %0d cycles", name, bad);
    end
    record_result(name, bad);
    name      = $sformatf("pass%0d_lock", pass_no);
    bad       = lock_errors - lock_base;
    lock_base = lock_errors;
    if (bad != 0) begin
      $display("[FAIL] %s: ctrl_lock wrong in %0d cycles", name, bad);
    end
    record_result(name, bad);
  endtask

endmodule

`default_nettype wire

// ==== sim/dcd_calibration_chk.sv ====
// Register port handshake assertions
`timescale 1ns/1ps
`default_nettype none

module dcd_calibration_chk (
  input logic               clk,
  input logic               reset,
  input logic               ctrl_go,
  input logic               ctrl_done,
  input logic               ctrl_lock,
  input logic               busy,
  input dcd_pkg::dcd_chan_t ctrl_chan
);

  logic access_open;

  // Open from go until the matching done
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      access_open <= 1'b0;
    end else if (ctrl_go) begin
      access_open <= 1'b1;
    end else if (ctrl_done) begin
      access_open <= 1'b0;
    end
  end

  idle_quiet: assert property (@(posedge clk) disable iff (reset)
    !busy |-> !ctrl_go && !ctrl_lock)
    else $error("Register port active while the controller is idle");

  go_pulse: assert property (@(posedge clk) disable iff (reset) ctrl_go |=> !ctrl_go)
    else $error("ctrl_go longer than one cycle");

  go_while_open: assert property (@(posedge clk) disable iff (reset) ctrl_go |-> !access_open)
    else $error("ctrl_go while an access is still open");

  chan_stable: assert property (@(posedge clk) disable iff (reset)
    ctrl_lock |=> !ctrl_lock || $stable(ctrl_chan))
    else $error("ctrl_chan changed while ctrl_lock is high");

endmodule

bind dcd_calibration_top dcd_calibration_chk chk (
  .clk       (clk),
  .reset     (reset),
  .ctrl_go   (ctrl_go),
  .ctrl_done (ctrl_done),
  .ctrl_lock (ctrl_lock),
  .busy      (busy),
  .ctrl_chan (ctrl_chan)
);

`default_nettype wire

// ==== sim/tb_dcd_calibration.sv ====
// DCD calibration testbench
`timescale 1ns/1ps
`default_nettype none
`include "dcd_cfg.svh"

module tb_dcd_calibration;

  // Worst case of one pass, doubled, for two passes plus reset time
  localparam int pass_cycles  = `DCD_NUM_CHANNELS * (12 * 5 + 8 * `DCD_SETTLE_CYCLES);
  localparam int limit_cycles = 2 * 2 * pass_cycles + 20;

  logic               clk = 1'b0;
  logic               reset;
  logic               start;
  logic               lch_atbout;
  logic               done;
  logic               busy;
  logic               ctrl_go;
  logic               ctrl_lock;
  logic               ctrl_done;
  dcd_pkg::dcd_chan_t ctrl_chan;
  logic               ctrl_chan_err;
  logic [11:0]        ctrl_addr;
  logic [2:0]         ctrl_opcode;
  dcd_pkg::dcd_word_u ctrl_wdata;
  dcd_pkg::dcd_word_u ctrl_rdata;
  int                 cycle_count = 0;
  int                 tests_passed;
  int                 tests_failed;

  always #20 clk = ~clk;

  dcd_calibration_top DUT (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .lch_atbout    (lch_atbout),
    .done          (done),
    .busy          (busy),
    .ctrl_go       (ctrl_go),
    .ctrl_lock     (ctrl_lock),
    .ctrl_done     (ctrl_done),
    .ctrl_chan     (ctrl_chan),
    .ctrl_chan_err (ctrl_chan_err),
    .ctrl_addr     (ctrl_addr),
    .ctrl_opcode   (ctrl_opcode),
    .ctrl_wdata    (ctrl_wdata),
    .ctrl_rdata    (ctrl_rdata)
  );

  dcd_xcvr_model xcvr (
    .clk           (clk),
    .reset         (reset),
    .ctrl_go       (ctrl_go),
    .ctrl_chan     (ctrl_chan),
    .ctrl_addr     (ctrl_addr),
    .ctrl_opcode   (ctrl_opcode),
    .ctrl_wdata    (ctrl_wdata),
    .ctrl_done     (ctrl_done),
    .ctrl_rdata    (ctrl_rdata),
    .ctrl_chan_err (ctrl_chan_err),
    .lch_atbout    (lch_atbout)
  );

  dcd_scoreboard board (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .done         (done),
    .busy         (busy),
    .ctrl_go      (ctrl_go),
    .ctrl_lock    (ctrl_lock),
    .ctrl_chan    (ctrl_chan),
    .ctrl_addr    (ctrl_addr),
    .ctrl_opcode  (ctrl_opcode),
    .tests_passed (tests_passed),
    .tests_failed (tests_failed)
  );

  // Sweep keeps the last setting before the comparator flips
  function automatic logic [2:0] expected_tune(input logic [2:0] threshold);
    if (threshold <= 3'd3) begin
      return threshold;
    end
    return threshold - 3'd1;
  endfunction

  task automatic setup_channel(input int ch, input int th_in, input bit req, input bit txp,
                               input bit err);
    logic [2:0] th;
    bit         cal;
    xcvr.configure(ch, th_in, req, txp, err, th);
    cal = req && txp && !err;
    board.expect_channel(ch, cal, expected_tune(th));
  endtask

  task automatic run_pass(input int pass_no);
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    while (!done) begin
      @(posedge clk);
      #1;
    end
    board.check_pass(pass_no);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= limit_cycles) begin
      $display("Timeout: no done after %0d cycles", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    start = 1'b0;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    board.check_idle();
    // Both sweep limits, then a skip by request and one by TX-present
    setup_channel(0, 0, 1'b1, 1'b1, 1'b0);
    setup_channel(1, 7, 1'b1, 1'b1, 1'b0);
    setup_channel(2, -1, 1'b0, 1'b1, 1'b0);
    setup_channel(3, -1, 1'b1, 1'b0, 1'b0);
    run_pass(1);
    repeat (3) @(posedge clk);
    #1;
    // New thresholds and a channel error
    setup_channel(0, -1, 1'b1, 1'b1, 1'b0);
    setup_channel(1, -1, 1'b1, 1'b1, 1'b1);
    setup_channel(2, -1, 1'b1, 1'b1, 1'b0);
    setup_channel(3, -1, 1'b1, 1'b1, 1'b0);
    run_pass(2);
    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/dcd_pkg.sv
verilog/dcd_comparator_monitor.sv
verilog/dcd_tune_search.sv
verilog/dcd_access_port.sv
verilog/dcd_sequencer.sv
verilog/dcd_calibration_top.sv
sim/dcd_xcvr_model.sv
sim/dcd_scoreboard.sv
sim/dcd_calibration_chk.sv
sim/tb_dcd_calibration.sv

// ==== Makefile ====
# Verilator simulation of the DCD calibration controller

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_dcd_calibration
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Testbench failed" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
